// ==== rtl/cache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module cache (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              enable,
   input  wire logic              comp,
   input  wire logic              write,
   input  wire logic              valid_in,
   input  wire mem_pkg::tag_t     tag_in,
   input  wire mem_pkg::index_t   index,
   input  wire mem_pkg::offset_t  offset,
   input  wire mem_pkg::word_t    data_in,
   output mem_pkg::tag_t          tag_out,
   output mem_pkg::word_t         data_out,
   output logic                   hit,
   output logic                   dirty,
   output logic                   valid
);

   localparam int LINES = `MEM_LINES;

   // Line storage
   mem_pkg::tag_t  tag_mem  [LINES];
   mem_pkg::word_t data_mem [LINES][`MEM_LINE_WORDS];

   // Per-line state bits
   logic [LINES-1:0] valid_r;
   logic [LINES-1:0] dirty_r;

   mem_pkg::bank_sel_t word_sel;
   logic               tag_match;
   logic               wr_access;
   logic               wr_compare;

   // Offset bit 0 is the byte within a word
   assign word_sel = offset[2:1];

   assign tag_match = (tag_mem[index] == tag_in);

   // Valid line with matching tag, only meaningful when comparing
   assign hit = comp && valid_r[index] && tag_match;

   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[index][word_sel];
   assign valid    = valid_r[index];
   assign dirty    = dirty_r[index];

   assign wr_access  = enable && write && !comp;
   assign wr_compare = enable && write && comp && hit;

   // Valid and dirty bits
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_r <= '0;
         dirty_r <= '0;
      end else if (wr_access) begin
         valid_r[index] <= valid_in;
         dirty_r[index] <= 1'b0;
      end else if (wr_compare) begin
         dirty_r[index] <= 1'b1;
      end
   end

   // Access mode installs the tag along with the word
   always_ff @(posedge clk) begin
      if (wr_access) begin
         tag_mem[index] <= tag_in;
      end
   end

   // Word writes, either a fill or a write hit
   always_ff @(posedge clk) begin
      if (wr_access || wr_compare) begin
         data_mem[index][word_sel] <= data_in;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/cache_cntrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module cache_cntrl (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              rd,
   input  wire logic              wr,
   input  wire mem_pkg::word_t    addr,
   input  wire mem_pkg::word_t    data_in,
   input  wire mem_pkg::word_t    data_out_cache,
   input  wire mem_pkg::word_t    data_out_mem,
   input  wire mem_pkg::tag_t     tag_out,
   input  wire logic              hit_cache,
   input  wire logic              dirty_cache,
   input  wire logic              valid_cache,
   input  wire logic              stall_mem,
   output logic                   enable_cntrl,
   output logic                   comp_cntrl,
   output logic                   write_cntrl,
   output logic                   valid_in_cntrl,
   output mem_pkg::index_t        idx_cntrl,
   output mem_pkg::offset_t       offset_cntrl,
   output mem_pkg::tag_t          tag_cntrl,
   output mem_pkg::word_t         data_in_cntrl,
   output mem_pkg::word_t         addr_in_mem,
   output mem_pkg::word_t         data_in_mem,
   output mem_pkg::word_t         data_out_cntrl,
   output logic                   write_mem,
   output logic                   read_mem,
   output logic                   done,
   output logic                   stall,
   output logic                   cache_hit,
   output logic                   err,
   output logic                   end_state
);

   mem_pkg::ctrl_state_t state;
   mem_pkg::ctrl_state_t state_nxt;

   // Latched request
   mem_pkg::word_t   req_addr;
   mem_pkg::word_t   req_data;
   logic             req_wr;
   mem_pkg::tag_t    req_tag;
   mem_pkg::index_t  req_index;
   mem_pkg::offset_t req_offset;

   // Words sent to memory and words back from it
   mem_pkg::bank_sel_t         iss_cnt;
   mem_pkg::bank_sel_t         ret_cnt;
   logic [`MEM_RD_LATENCY-1:0] rd_pipe;
   logic                       ret_valid;

   logic accept;
   logic bad_req;
   logic mem_accept;

   assign req_tag    = req_addr[`MEM_WORD_W-1 -: `MEM_TAG_W];
   assign req_index  = req_addr[`MEM_OFFSET_W +: `MEM_INDEX_W];
   assign req_offset = req_addr[`MEM_OFFSET_W-1:0];

   assign cache_hit = (state == mem_pkg::st_compare) && hit_cache;
   assign err       = (state == mem_pkg::st_error);
   assign done      = cache_hit || err || (state == mem_pkg::st_done);
   assign end_state = done;
   assign stall     = (state != mem_pkg::st_idle) && !done;

   // New request taken in idle or in the cycle that finishes the last one
   assign accept  = (rd || wr) && ((state == mem_pkg::st_idle) || done);
   assign bad_req = addr[0] || (rd && wr);

   assign ret_valid  = rd_pipe[`MEM_RD_LATENCY-1];
   assign mem_accept = (read_mem || write_mem) && !stall_mem;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mem_pkg::st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_data <= data_in;
         req_wr   <= wr;
      end
   end

   // Issue and return counters run apart so fill reads overlap
   always_ff @(posedge clk) begin
      if (rst) begin
         iss_cnt <= '0;
         ret_cnt <= '0;
         rd_pipe <= '0;
      end else begin
         rd_pipe <= {rd_pipe[`MEM_RD_LATENCY-2:0], read_mem && !stall_mem};
         if (accept) begin
            iss_cnt <= '0;
            ret_cnt <= '0;
         end else begin
            if (mem_accept) begin
               iss_cnt <= iss_cnt + 1'b1;
            end
            if (ret_valid) begin
               ret_cnt <= ret_cnt + 1'b1;
            end
         end
      end
   end

   always_comb begin
      state_nxt = state;
      if (accept) begin
         state_nxt = bad_req ? mem_pkg::st_error : mem_pkg::st_compare;
      end else if (done) begin
         state_nxt = mem_pkg::st_idle;
      end else begin
         case (state)
            mem_pkg::st_compare: begin
               // Dirty victim goes back to memory first
               state_nxt = (valid_cache && dirty_cache) ? mem_pkg::st_writeback
                                                        : mem_pkg::st_fill_req;
            end
            mem_pkg::st_writeback: begin
               if (mem_accept && (&iss_cnt)) begin
                  state_nxt = mem_pkg::st_fill_req;
               end
            end
            mem_pkg::st_fill_req: begin
               if (mem_accept && (&iss_cnt)) begin
                  state_nxt = mem_pkg::st_fill_wait;
               end
            end
            mem_pkg::st_fill_wait: begin
               if (ret_valid && (&ret_cnt)) begin
                  state_nxt = mem_pkg::st_install;
               end
            end
            mem_pkg::st_install: state_nxt = mem_pkg::st_done;
            default: state_nxt = state;
         endcase
      end
   end

   // Cache and memory drive
   always_comb begin
      enable_cntrl   = 1'b0;
      comp_cntrl     = 1'b0;
      write_cntrl    = 1'b0;
      valid_in_cntrl = 1'b0;
      idx_cntrl      = req_index;
      tag_cntrl      = req_tag;
      offset_cntrl   = req_offset;
      data_in_cntrl  = req_data;
      addr_in_mem    = {req_tag, req_index, iss_cnt, 1'b0};
      data_in_mem    = data_out_cache;
      write_mem      = 1'b0;
      read_mem       = 1'b0;
      case (state)
         mem_pkg::st_compare, mem_pkg::st_install, mem_pkg::st_done: begin
            enable_cntrl = 1'b1;
            comp_cntrl   = 1'b1;
            write_cntrl  = req_wr && (state != mem_pkg::st_done);
         end
         mem_pkg::st_writeback: begin
            enable_cntrl = 1'b1;
            offset_cntrl = {iss_cnt, 1'b0};
            addr_in_mem  = {tag_out, req_index, iss_cnt, 1'b0};
            write_mem    = 1'b1;
         end
         mem_pkg::st_fill_req, mem_pkg::st_fill_wait: begin
            read_mem       = (state == mem_pkg::st_fill_req);
            enable_cntrl   = ret_valid;
            write_cntrl    = ret_valid;
            offset_cntrl   = {ret_cnt, 1'b0};
            data_in_cntrl  = data_out_mem;
            // Line turns valid with its last word
            valid_in_cntrl = &ret_cnt;
         end
         default: begin
            enable_cntrl = 1'b0;
         end
      endcase
   end

   assign data_out_cntrl = data_out_cache;

endmodule

`default_nettype wire

// ==== rtl/four_bank_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module four_bank_mem (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire mem_pkg::word_t   addr,
   input  wire mem_pkg::word_t   data_in,
   input  wire logic             wr,
   input  wire logic             rd,
   output mem_pkg::word_t        data_out,
   output logic                  stall,
   output logic [`MEM_BANKS-1:0] busy
);

   localparam int ROW_W = `MEM_WORD_W - `MEM_BANK_W - 1;
   localparam logic [`MEM_BUSY_W-1:0] BUSY_LOAD = `MEM_BUSY_W'(`MEM_BANK_BUSY);

   // Word storage, zero at start of simulation
   mem_pkg::word_t bank_mem [`MEM_BANKS][`MEM_BANK_ROWS] = '{default: '0};

   logic [`MEM_BUSY_W-1:0] busy_cnt [`MEM_BANKS];

   // Read data delay line
   mem_pkg::word_t rd_pipe [`MEM_RD_LATENCY];

   mem_pkg::bank_sel_t bank;
   logic [ROW_W-1:0]   row;
   logic               req;
   logic               accept;
   logic               rd_go;
   logic               wr_go;

   assign bank = addr[`MEM_BANK_W:1];
   assign row  = addr[`MEM_WORD_W-1:`MEM_BANK_W+1];

   always_comb begin
      for (int b = 0; b < `MEM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   // A busy bank refuses the access, the requester repeats it
   assign req    = rd || wr;
   assign stall  = req && busy[bank];
   assign accept = req && !busy[bank];

   // Write wins if both strobes come together
   assign wr_go = accept && wr;
   assign rd_go = accept && rd && !wr;

   always_ff @(posedge clk) begin
      for (int b = 0; b < `MEM_BANKS; b++) begin
         if (rst) begin
            busy_cnt[b] <= '0;
         end else if (accept && (bank == mem_pkg::bank_sel_t'(b))) begin
            busy_cnt[b] <= BUSY_LOAD;
         end else if (busy[b]) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

   // Writes land at acceptance
   always_ff @(posedge clk) begin
      if (wr_go) begin
         bank_mem[bank][row] <= data_in;
      end
   end

   // Stage 0 loads on an accepted read, later stages shift every cycle
   always_ff @(posedge clk) begin
      if (rd_go) begin
         rd_pipe[0] <= bank_mem[bank][row];
      end
      for (int s = 1; s < `MEM_RD_LATENCY; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign data_out = rd_pipe[`MEM_RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Word and address width
`define MEM_WORD_W      16

// Byte address split
`define MEM_TAG_W       5
`define MEM_INDEX_W     8
`define MEM_OFFSET_W    3

// Cache geometry
`define MEM_LINE_WORDS  4
`define MEM_LINES       256

// Main memory organization, banks picked by address bits 2:1
`define MEM_BANKS       4
`define MEM_BANK_W      2
`define MEM_BANK_ROWS   8192

// Memory timing in cycles
`define MEM_BANK_BUSY   4
`define MEM_BUSY_W      3
`define MEM_RD_LATENCY  2

`endif

// ==== rtl/mem_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

   // One memory or cache word
   typedef logic [`MEM_WORD_W-1:0] word_t;

   // Fields of a byte address
   typedef logic [`MEM_TAG_W-1:0]    tag_t;
   typedef logic [`MEM_INDEX_W-1:0]  index_t;
   typedef logic [`MEM_OFFSET_W-1:0] offset_t;

   // Bank number, same as word position in a line
   typedef logic [`MEM_BANK_W-1:0] bank_sel_t;

   // Miss handling FSM
   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_writeback,
      st_fill_req,
      st_fill_wait,
      st_install,
      st_done,
      st_error
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_system (
   input  wire mem_pkg::word_t addr,
   input  wire mem_pkg::word_t data_in,
   input  wire logic           rd,
   input  wire logic           wr,
   input  wire logic           clk,
   input  wire logic           rst,
   output mem_pkg::word_t      data_out,
   output logic                done,
   output logic                stall,
   output logic                cache_hit,
   output logic                err
);

   mem_pkg::word_t   data_out_cache;
   mem_pkg::word_t   data_out_mem;
   mem_pkg::word_t   data_out_cntrl;
   mem_pkg::word_t   data_in_cntrl;
   mem_pkg::word_t   data_in_mem;
   mem_pkg::word_t   addr_in_mem;
   mem_pkg::word_t   data_held;
   mem_pkg::tag_t    tag_out;
   mem_pkg::tag_t    tag_cntrl;
   mem_pkg::index_t  idx_cntrl;
   mem_pkg::offset_t offset_cntrl;
   logic             hit_cache;
   logic             dirty_cache;
   logic             valid_cache;
   logic             enable_cntrl;
   logic             comp_cntrl;
   logic             write_cntrl;
   logic             valid_in_cntrl;
   logic             write_mem;
   logic             read_mem;
   logic             stall_mem;
   logic             done_state;

   cache c0 (
      .clk      (clk),
      .rst      (rst),
      .enable   (enable_cntrl),
      .comp     (comp_cntrl),
      .write    (write_cntrl),
      .valid_in (valid_in_cntrl),
      .tag_in   (tag_cntrl),
      .index    (idx_cntrl),
      .offset   (offset_cntrl),
      .data_in  (data_in_cntrl),
      .tag_out  (tag_out),
      .data_out (data_out_cache),
      .hit      (hit_cache),
      .dirty    (dirty_cache),
      .valid    (valid_cache)
   );

   four_bank_mem mem (
      .clk      (clk),
      .rst      (rst),
      .addr     (addr_in_mem),
      .data_in  (data_in_mem),
      .wr       (write_mem),
      .rd       (read_mem),
      .data_out (data_out_mem),
      .stall    (stall_mem),
      .busy     ()
   );

   cache_cntrl controller (
      .clk            (clk),
      .rst            (rst),
      .rd             (rd),
      .wr             (wr),
      .addr           (addr),
      .data_in        (data_in),
      .data_out_cache (data_out_cache),
      .data_out_mem   (data_out_mem),
      .tag_out        (tag_out),
      .hit_cache      (hit_cache),
      .dirty_cache    (dirty_cache),
      .valid_cache    (valid_cache),
      .stall_mem      (stall_mem),
      .enable_cntrl   (enable_cntrl),
      .comp_cntrl     (comp_cntrl),
      .write_cntrl    (write_cntrl),
      .valid_in_cntrl (valid_in_cntrl),
      .idx_cntrl      (idx_cntrl),
      .offset_cntrl   (offset_cntrl),
      .tag_cntrl      (tag_cntrl),
      .data_in_cntrl  (data_in_cntrl),
      .addr_in_mem    (addr_in_mem),
      .data_in_mem    (data_in_mem),
      .data_out_cntrl (data_out_cntrl),
      .write_mem      (write_mem),
      .read_mem       (read_mem),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .err            (err),
      .end_state      (done_state)
   );

   // Keeps the last delivered word until the next Done
   always_ff @(posedge clk) begin
      if (rst) begin
         data_held <= '0;
      end else if (done_state) begin
         data_held <= data_out_cntrl;
      end
   end

   assign data_out = done_state ? data_out_cntrl : data_held;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/cache.sv
rtl/four_bank_mem.sv
rtl/cache_cntrl.sv
rtl/mem_system.sv
test/mem_system_tb.sv

// ==== test/mem_system_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_system_tb;

   localparam int TIMEOUT   = 200;
   localparam int MEM_WORDS = 1 << (`MEM_WORD_W - 1);
   localparam int LINES     = 1 << `MEM_INDEX_W;

   logic                   clk = 1'b0;
   logic                   rst;
   logic [`MEM_WORD_W-1:0] addr;
   logic [`MEM_WORD_W-1:0] data_in;
   logic                   rd;
   logic                   wr;
   logic [`MEM_WORD_W-1:0] data_out;
   logic                   done;
   logic                   stall;
   logic                   cache_hit;
   logic                   err;

   // Reference memory and a mirror of the cache tags
   logic [`MEM_WORD_W-1:0] model_mem   [MEM_WORDS];
   logic                   model_valid [LINES];
   logic [`MEM_TAG_W-1:0]  model_tag   [LINES];

   // Word that data_out must keep while a request is pending
   logic                   hold_check;
   logic [`MEM_WORD_W-1:0] hold_word;

   integer seed = 32'h8f790272;

   mem_system UUT (
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .clk       (clk),
      .rst       (rst),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_value(input string test, input string what,
                              input logic [15:0] exp, input logic [15:0] act);
      assert (act === exp) else begin
         $display("Fail %s %s: expected %h, actual %h", test, what, exp, act);
         abort_run();
      end
   endtask

   // One strobe and then a wait for Done at falling edges
   task automatic request(input string test, input logic do_rd, input logic do_wr,
                          input logic [15:0] a, input logic [15:0] d,
                          output logic [15:0] rdata, output logic hit,
                          output logic error, output int latency);
      int cycles;
      cycles = 0;
      while (stall === 1'b1) begin
         assert (cycles < TIMEOUT) else begin
            $display("Timeout in %s: stall never went low", test);
            abort_run();
         end
         @(negedge clk);
         cycles++;
      end
      @(posedge clk);
      addr    <= a;
      data_in <= d;
      rd      <= do_rd;
      wr      <= do_wr;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      @(negedge clk);
      latency = 1;
      while (done !== 1'b1) begin
         assert (latency < TIMEOUT) else begin
            $display("Timeout in %s: done never arrived", test);
            abort_run();
         end
         check_value(test, "stall while busy", 1'b1, stall);
         if (hold_check) begin
            check_value(test, "held data_out", hold_word, data_out);
         end
         @(negedge clk);
         latency++;
      end
      check_value(test, "stall during done", 1'b0, stall);
      rdata = data_out;
      hit   = cache_hit;
      error = err;
   endtask

   // Checks a valid request against the model and then updates the model
   task automatic model_access(input string test, input logic is_wr,
                               input logic [15:0] a, input logic [15:0] d);
      logic [15:0]           rdata;
      logic                  hit;
      logic                  error;
      int                    lat;
      logic                  exp_hit;
      logic [`MEM_INDEX_W-1:0] idx;
      logic [`MEM_TAG_W-1:0]   tg;
      idx     = a[`MEM_OFFSET_W +: `MEM_INDEX_W];
      tg      = a[`MEM_WORD_W-1 -: `MEM_TAG_W];
      exp_hit = model_valid[idx] && (model_tag[idx] == tg);
      request(test, !is_wr, is_wr, a, d, rdata, hit, error, lat);
      check_value(test, "cache_hit", exp_hit, hit);
      check_value(test, "err", 1'b0, error);
      if (exp_hit) begin
         check_value(test, "hit latency", 16'd1, lat[15:0]);
      end
      model_valid[idx] = 1'b1;
      model_tag[idx]   = tg;
      if (is_wr) begin
         model_mem[a[15:1]] = d;
      end else begin
         check_value(test, "data_out", model_mem[a[15:1]], rdata);
      end
   endtask

   task automatic test_reset();
      logic [15:0] a;
      check_value("reset", "done", 1'b0, done);
      check_value("reset", "stall", 1'b0, stall);
      check_value("reset", "cache_hit", 1'b0, cache_hit);
      check_value("reset", "err", 1'b0, err);
      a = $random(seed);
      a[0] = 1'b0;
      model_access("reset", 1'b0, a, 16'h0);
   endtask

   task automatic test_write_read();
      model_access("write_read", 1'b1, {5'd2, 8'd20, 3'd4}, 16'hbeef);
      model_access("write_read", 1'b0, {5'd2, 8'd20, 3'd4}, 16'h0);
      model_access("write_read", 1'b0, {5'd2, 8'd20, 3'd0}, 16'h0);
   endtask

   task automatic test_hit_timing();
      logic [15:0] rdata;
      logic        hit;
      logic        error;
      int          lat;
      request("hit_timing", 1'b1, 1'b0, {5'd2, 8'd20, 3'd4}, 16'h0, rdata, hit, error, lat);
      check_value("hit_timing", "latency", 16'd1, lat[15:0]);
      check_value("hit_timing", "cache_hit", 1'b1, hit);
      check_value("hit_timing", "data_out", 16'hbeef, rdata);
      // Output holds while idle
      repeat (4) begin
         @(negedge clk);
         check_value("hit_timing", "held data_out", 16'hbeef, data_out);
      end
      // Also held through the stall of a later miss on another line
      hold_word  = 16'hbeef;
      hold_check = 1'b1;
      model_access("hit_timing", 1'b0, {5'd4, 8'd60, 3'd0}, 16'h0);
      hold_check = 1'b0;
   endtask

   task automatic test_eviction();
      model_access("eviction", 1'b1, {5'd3, 8'd40, 3'd2}, 16'h1111);
      model_access("eviction", 1'b1, {5'd9, 8'd40, 3'd2}, 16'h2222);
      model_access("eviction", 1'b0, {5'd3, 8'd40, 3'd2}, 16'h0);
      model_access("eviction", 1'b0, {5'd9, 8'd40, 3'd2}, 16'h0);
   endtask

   task automatic test_random();
      logic [`MEM_TAG_W-1:0]   tg;
      logic [`MEM_INDEX_W-1:0] idx;
      logic [1:0]              word;
      logic                    is_wr;
      logic [15:0]             d;
      for (int i = 0; i < 40; i++) begin
         tg    = ($random(seed) & 1) ? 5'd12 : 5'd21;
         idx   = 8'd100 + 8'($random(seed) & 3);
         word  = $random(seed);
         is_wr = $random(seed);
         d     = $random(seed);
         model_access("random", is_wr, {tg, idx, word, 1'b0}, d);
      end
   endtask

   task automatic test_errors();
      logic [15:0] rdata;
      logic        hit;
      logic        error;
      int          lat;
      request("errors", 1'b0, 1'b1, {5'd2, 8'd20, 3'd5}, 16'hdead, rdata, hit, error, lat);
      check_value("errors", "odd err", 1'b1, error);
      check_value("errors", "odd cache_hit", 1'b0, hit);
      check_value("errors", "odd latency", 16'd1, lat[15:0]);
      request("errors", 1'b1, 1'b1, {5'd9, 8'd40, 3'd2}, 16'hdead, rdata, hit, error, lat);
      check_value("errors", "rd_wr err", 1'b1, error);
      check_value("errors", "rd_wr cache_hit", 1'b0, hit);
      check_value("errors", "rd_wr latency", 16'd1, lat[15:0]);
      model_access("errors", 1'b0, {5'd2, 8'd20, 3'd4}, 16'h0);
      model_access("errors", 1'b0, {5'd9, 8'd40, 3'd2}, 16'h0);
   endtask

   initial begin
      rst        = 1'b1;
      rd         = 1'b0;
      wr         = 1'b0;
      addr       = '0;
      data_in    = '0;
      hold_check = 1'b0;
      hold_word  = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         model_mem[i] = '0;
      end
      for (int i = 0; i < LINES; i++) begin
         model_valid[i] = 1'b0;
         model_tag[i]   = '0;
      end
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      test_reset();
      test_write_read();
      test_hit_timing();
      test_eviction();
      test_random();
      test_errors();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire
